// File: src/gen3_defines.svh
`ifndef GEN3_DEFINES_SVH
`define GEN3_DEFINES_SVH

// Data word width on the lane interface
`define GEN3_WORD_W 32

// Four symbols per word, symbol 0 in bits 7:0
`define GEN3_SYMS_PER_WORD 4

// Four words make one 16-symbol block
`define GEN3_WORDS_PER_BLOCK 4

// LFSR state width
`define GEN3_LFSR_W 24

`endif

// File: src/pcie_sym_pkg.sv
`default_nettype none

`include "gen3_defines.svh"

package pcie_sym_pkg;

  // Ordered-set identifier symbols (symbol 0 of the block)
  localparam logic [7:0] SYM_TS1 = 8'h1E;
  localparam logic [7:0] SYM_TS2 = 8'h2D;
  localparam logic [7:0] SYM_SKP = 8'hAA;
  localparam logic [7:0] SYM_EIEOS = 8'h00;

  // EIEOS alternates 00 and FF, so symbol 1 tells it apart
  localparam logic [7:0] SYM_EIE_FILL = 8'hFF;

  // Sync header of a 128b/130b block
  // Codes 00 and 11 are illegal and get handled like data
  typedef enum logic [1:0] {
    SYNC_DATA = 2'b01,
    SYNC_OS   = 2'b10
  } sync_hdr_t;

  // Block class decided on word 0
  typedef enum logic [2:0] {
    BLK_DATA     = 3'd0,
    BLK_TS       = 3'd1,
    BLK_SKP      = 3'd2,
    BLK_EIEOS    = 3'd3,
    BLK_OS_OTHER = 3'd4
  } blk_kind_t;

  // One lane word, seen either as four symbols or as an ordered-set header
  typedef union packed {
    // Byte view, sym[0] is sent first
    logic [`GEN3_SYMS_PER_WORD-1:0][7:0] sym;
    // Ordered-set view of word 0
    struct packed {
      // rest[0] is symbol 1
      logic [`GEN3_SYMS_PER_WORD-2:0][7:0] rest;
      // Symbol 0 identifies the set
      logic [7:0] id;
    } os;
  } gen3_word_u;

endpackage

`default_nettype wire

// File: src/gen3_lfsr_pkg.sv
`default_nettype none

`include "gen3_defines.svh"

package gen3_lfsr_pkg;

  typedef logic [`GEN3_LFSR_W-1:0] lfsr_t;

  // Feedback taps for x^23+x^21+x^16+x^8+x^5+x^2+1
  // Galois form, the x^23 term folds back into these bits
  localparam lfsr_t GEN3_POLY = 24'h21_0125;

  // Lane seeds, picked by lane number modulo 8
  localparam lfsr_t gen3_seed [8] = '{
    24'h1D_BFBC,
    24'h06_07BB,
    24'h1E_C760,
    24'h18_C0DB,
    24'h01_0F12,
    24'h19_CFC9,
    24'h02_77CE,
    24'h1B_B807
  };

  // Eight LFSR steps for one symbol
  // bits_o[0] is the first step and scrambles the symbol LSB
  function automatic lfsr_t lfsr_advance8(input lfsr_t state_i, output logic [7:0] bits_o);
    lfsr_t s;
    logic  fb;
    s = state_i;
    for (int i = 0; i < 8; i++) begin
      // Output taken from the top stage (bit 22)
      fb        = s[`GEN3_LFSR_W-2];
      bits_o[i] = fb;
      // Shift up by one, bit 23 stays clear
      s = {1'b0, s[`GEN3_LFSR_W-3:0], 1'b0};
      if (fb) begin
        s = s ^ GEN3_POLY;
      end
    end
    return s;
  endfunction

endpackage

`default_nettype wire

// File: src/gen3_block_tracker.sv
`default_nettype none

`include "gen3_defines.svh"

module gen3_block_tracker
  import pcie_sym_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    valid_i,
  input  sync_hdr_t               sync_header_i,
  input  logic [`GEN3_WORD_W-1:0] data_i,
  output logic                    valid_o,
  output sync_hdr_t               sync_header_o,
  output logic [`GEN3_WORD_W-1:0] data_o,
  output logic [1:0]              word_idx_o,
  output blk_kind_t               blk_kind_o
);

  localparam logic [1:0] LAST_WORD = 2'(`GEN3_WORDS_PER_BLOCK - 1);

  logic [1:0] word_cnt;
  sync_hdr_t  sync_q;
  blk_kind_t  kind_q;
  blk_kind_t  kind_c;
  blk_kind_t  kind_now;
  sync_hdr_t  sync_now;
  gen3_word_u word;

  assign word = data_i;

  // Classify from the ordered-set header view
  always_comb begin : classify
    kind_c = BLK_DATA;
    if (sync_header_i == SYNC_OS) begin
      case (word.os.id)
        SYM_TS1, SYM_TS2: kind_c = BLK_TS;
        SYM_SKP:          kind_c = BLK_SKP;
        // A 00 id alone is not enough, symbol 1 must be FF
        SYM_EIEOS:        kind_c = (word.os.rest[0] == SYM_EIE_FILL) ? BLK_EIEOS : BLK_OS_OTHER;
        default:          kind_c = BLK_OS_OTHER;
      endcase
    end
  end

  // Word 0 uses the fresh decode, later words the held one
  assign kind_now = (word_cnt == 2'd0) ? kind_c : kind_q;
  assign sync_now = (word_cnt == 2'd0) ? sync_header_i : sync_q;

  // Block position and held class
  always_ff @(posedge clk_i) begin : ctrl_reg
    if (rst_i) begin
      word_cnt <= 2'd0;
      sync_q   <= SYNC_DATA;
      kind_q   <= BLK_DATA;
      valid_o  <= 1'b0;
    end else begin
      valid_o <= valid_i;
      // Gaps hold the counter
      if (valid_i) begin
        word_cnt <= (word_cnt == LAST_WORD) ? 2'd0 : word_cnt + 2'd1;
        if (word_cnt == 2'd0) begin
          sync_q <= sync_header_i;
          kind_q <= kind_c;
        end
      end
    end
  end

  // Word and its tags
  always_ff @(posedge clk_i) begin : data_reg
    data_o        <= data_i;
    word_idx_o    <= word_cnt;
    blk_kind_o    <= kind_now;
    sync_header_o <= sync_now;
  end

endmodule

`default_nettype wire

// File: src/gen3_scrambler.sv
`default_nettype none

`include "gen3_defines.svh"

module gen3_scrambler
  import pcie_sym_pkg::*;
  import gen3_lfsr_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [2:0]              lane_i,
  input  logic                    valid_i,
  input  sync_hdr_t               sync_header_i,
  input  logic [`GEN3_WORD_W-1:0] data_i,
  input  logic [1:0]              word_idx_i,
  input  blk_kind_t               blk_kind_i,
  output logic                    valid_o,
  output sync_hdr_t               sync_header_o,
  output logic [`GEN3_WORD_W-1:0] data_o
);

  localparam logic [1:0] LAST_WORD = 2'(`GEN3_WORDS_PER_BLOCK - 1);

  lfsr_t      lfsr_q;
  // chain[s] is the state before symbol s
  lfsr_t      chain [`GEN3_SYMS_PER_WORD+1];
  logic [7:0] key [`GEN3_SYMS_PER_WORD];
  logic       bypass [`GEN3_SYMS_PER_WORD];
  gen3_word_u word_in;
  gen3_word_u word_out;

  assign word_in = data_i;

  // Per-symbol keystream and bypass
  always_comb begin : scramble
    chain[0] = lfsr_q;
    word_out = word_in;
    for (int s = 0; s < `GEN3_SYMS_PER_WORD; s++) begin
      chain[s+1] = lfsr_advance8(chain[s], key[s]);
      case (blk_kind_i)
        BLK_DATA: bypass[s] = 1'b0;
        // Only the TS identifier stays in the clear
        BLK_TS:   bypass[s] = (s == 0) && (word_idx_i == 2'd0);
        // SKP, EIEOS and other sets go out as they are
        default:  bypass[s] = 1'b1;
      endcase
      if (!bypass[s]) begin
        word_out.sym[s] = word_in.sym[s] ^ key[s];
      end
    end
  end

  // LFSR state
  always_ff @(posedge clk_i) begin : lfsr_reg
    if (rst_i) begin
      lfsr_q <= gen3_seed[lane_i];
    end else if (valid_i) begin
      // Reseed once the last EIEOS symbol is through
      if (blk_kind_i == BLK_EIEOS && word_idx_i == LAST_WORD) begin
        lfsr_q <= gen3_seed[lane_i];
      end else if (blk_kind_i != BLK_SKP) begin
        lfsr_q <= chain[`GEN3_SYMS_PER_WORD];
      end
      // SKP blocks leave the LFSR where it is
    end
  end

  always_ff @(posedge clk_i) begin : valid_reg
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Sync header is never scrambled
  always_ff @(posedge clk_i) begin : data_reg
    data_o        <= word_out;
    sync_header_o <= sync_header_i;
  end

endmodule

`default_nettype wire

// File: src/gen3_lane_loopback.sv
`default_nettype none

`include "gen3_defines.svh"

module gen3_lane_loopback
  import pcie_sym_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [2:0]              lane_i,
  input  logic                    valid_i,
  input  sync_hdr_t               sync_header_i,
  input  logic [`GEN3_WORD_W-1:0] data_i,
  output logic                    scr_valid_o,
  output sync_hdr_t               scr_sync_o,
  output logic [`GEN3_WORD_W-1:0] scr_data_o,
  output logic                    rx_valid_o,
  output sync_hdr_t               rx_sync_o,
  output logic [`GEN3_WORD_W-1:0] rx_data_o
);

  // Transmit tracker to transmit scrambler
  logic                    tx_trk_valid;
  sync_hdr_t               tx_trk_sync;
  logic [`GEN3_WORD_W-1:0] tx_trk_data;
  logic [1:0]              tx_trk_idx;
  blk_kind_t               tx_trk_kind;

  // Receive tracker to receive scrambler
  logic                    rx_trk_valid;
  sync_hdr_t               rx_trk_sync;
  logic [`GEN3_WORD_W-1:0] rx_trk_data;
  logic [1:0]              rx_trk_idx;
  blk_kind_t               rx_trk_kind;

  gen3_block_tracker tx_trk (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .valid_i       (valid_i),
    .sync_header_i (sync_header_i),
    .data_i        (data_i),
    .valid_o       (tx_trk_valid),
    .sync_header_o (tx_trk_sync),
    .data_o        (tx_trk_data),
    .word_idx_o    (tx_trk_idx),
    .blk_kind_o    (tx_trk_kind)
  );

  gen3_scrambler tx_scr (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lane_i        (lane_i),
    .valid_i       (tx_trk_valid),
    .sync_header_i (tx_trk_sync),
    .data_i        (tx_trk_data),
    .word_idx_i    (tx_trk_idx),
    .blk_kind_i    (tx_trk_kind),
    .valid_o       (scr_valid_o),
    .sync_header_o (scr_sync_o),
    .data_o        (scr_data_o)
  );

  // Ordered sets bypass, so the scrambled stream classifies the same way
  gen3_block_tracker rx_trk (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .valid_i       (scr_valid_o),
    .sync_header_i (scr_sync_o),
    .data_i        (scr_data_o),
    .valid_o       (rx_trk_valid),
    .sync_header_o (rx_trk_sync),
    .data_o        (rx_trk_data),
    .word_idx_o    (rx_trk_idx),
    .blk_kind_o    (rx_trk_kind)
  );

  // Same keystream XOR undoes the scrambling
  gen3_scrambler rx_scr (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lane_i        (lane_i),
    .valid_i       (rx_trk_valid),
    .sync_header_i (rx_trk_sync),
    .data_i        (rx_trk_data),
    .word_idx_i    (rx_trk_idx),
    .blk_kind_i    (rx_trk_kind),
    .valid_o       (rx_valid_o),
    .sync_header_o (rx_sync_o),
    .data_o        (rx_data_o)
  );

endmodule

`default_nettype wire

// File: tb/gen3_lane_asserts.sv
`default_nettype none

module gen3_lane_asserts
  import pcie_sym_pkg::*;
(
  input logic      clk_i,
  input logic      rst_i,
  input logic      valid_i,
  input sync_hdr_t sync_header_i,
  input logic      scr_valid_i,
  input logic      rx_valid_i,
  input sync_hdr_t rx_sync_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Tracker plus scrambler, two register stages
  scr_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    scr_valid_i == $past(valid_i, 2))
    else $error("scr_valid_o does not follow valid_i by 2 cycles");

  // Full loopback, four stages
  rx_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_valid_i == $past(valid_i, 4))
    else $error("rx_valid_o does not follow valid_i by 4 cycles");

  // Reset clears every valid stage
  reset_clears: assert property (@(posedge clk_i)
    $past(rst_i) |-> !scr_valid_i && !rx_valid_i)
    else $error("valid output high in the cycle after reset");

  // Sync header travels unscrambled through both paths
  rx_sync_match: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_valid_i |-> rx_sync_i == $past(sync_header_i, 4))
    else $error("rx_sync_o differs from sync_header_i 4 cycles earlier");

endmodule

bind gen3_lane_loopback gen3_lane_asserts asserts0 (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .valid_i       (valid_i),
  .sync_header_i (sync_header_i),
  .scr_valid_i   (scr_valid_o),
  .rx_valid_i    (rx_valid_o),
  .rx_sync_i     (rx_sync_o)
);

`default_nettype wire

// File: tb/gen3_lane_tb.sv
`default_nettype none

`include "gen3_defines.svh"

module gen3_lane_tb
  import pcie_sym_pkg::*;
  import gen3_lfsr_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RST_CYCLES = 10;
  localparam int NUM_RESETS = 4;
  // Words per test: 1, 2, 3, 4, 6
  localparam int TOTAL_WORDS = 24 + 12 + 20 + 12 + 42;
  localparam int CYCLE_LIMIT = 2 * TOTAL_WORDS + NUM_RESETS * RST_CYCLES + 20;

  logic                    clk = 1'b0;
  logic                    rst;
  logic [2:0]              lane;
  logic                    valid;
  sync_hdr_t               sync_hdr;
  logic [`GEN3_WORD_W-1:0] data;
  logic                    scr_valid;
  sync_hdr_t               scr_sync;
  logic [`GEN3_WORD_W-1:0] scr_data;
  logic                    rx_valid;
  sync_hdr_t               rx_sync;
  logic [`GEN3_WORD_W-1:0] rx_data;

  // Queue entries are {sync, word}
  logic [33:0] stim_q [$];
  logic [33:0] exp_scr_q [$];
  logic [33:0] exp_rx_q [$];
  logic [33:0] stim_word;
  logic [33:0] scr_exp;
  logic [33:0] rx_exp;
  logic [31:0] part_word;
  lfsr_t       model_lfsr;
  integer      seed = 32'h92e3_3951;
  int          gap_pct;
  int          errors = 0;
  int          other_errors = 0;
  int          rx_errors = 0;
  int          errors_before_rx;
  int          checks = 0;
  int          err_mark;
  int          cycles;

  gen3_lane_loopback dut0 (
    .clk_i         (clk),
    .rst_i         (rst),
    .lane_i        (lane),
    .valid_i       (valid),
    .sync_header_i (sync_hdr),
    .data_i        (data),
    .scr_valid_o   (scr_valid),
    .scr_sync_o    (scr_sync),
    .scr_data_o    (scr_data),
    .rx_valid_o    (rx_valid),
    .rx_sync_o     (rx_sync),
    .rx_data_o     (rx_data)
  );

  always #5 clk = ~clk;

  // Bit-serial model of x^23+x^21+x^16+x^8+x^5+x^2+1, output from stage 22
  function automatic logic [31:0] ref_scramble(input logic [31:0] word, input blk_kind_t kind,
                                               input int idx);
    logic [31:0] res;
    lfsr_t       st;
    logic        fb;
    logic        scramble_on;
    res = word;
    st  = model_lfsr;
    for (int s = 0; s < 4; s++) begin
      // TS identifier is the only TS symbol in the clear
      scramble_on = (kind == BLK_DATA) || (kind == BLK_TS && (s != 0 || idx != 0));
      for (int k = 0; k < 8; k++) begin
        fb = st[22];
        if (scramble_on) begin
          res[8*s+k] = word[8*s+k] ^ fb;
        end
        st = {1'b0, st[21:0], 1'b0};
        st[0] = fb;
        st[2] ^= fb;
        st[5] ^= fb;
        st[8] ^= fb;
        st[16] ^= fb;
        st[21] ^= fb;
      end
    end
    // EIEOS reseeds after its last word, SKP freezes the state
    if (kind == BLK_EIEOS && idx == 3) begin
      model_lfsr = gen3_seed[lane];
    end else if (kind != BLK_SKP) begin
      model_lfsr = st;
    end
    return res;
  endfunction

  function automatic logic draw_gap();
    logic [31:0] r;
    r = $random(seed);
    return (gap_pct != 0) && (r % 100 < gap_pct);
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic push_word(input logic [1:0] sync, input logic [31:0] word,
                           input blk_kind_t kind, input int idx);
    logic [31:0] scr;
    scr = ref_scramble(word, kind, idx);
    stim_q.push_back({sync, word});
    exp_scr_q.push_back({sync, scr});
    // Loopback must give the input back
    exp_rx_q.push_back({sync, word});
  endtask

  task automatic send_block(input blk_kind_t kind, input logic [7:0] id);
    logic [31:0] w;
    logic [1:0]  sync;
    sync = (kind == BLK_DATA) ? 2'b01 : 2'b10;
    for (int i = 0; i < 4; i++) begin
      w = $random(seed);
      case (kind)
        BLK_SKP:   w = {4{SYM_SKP}};
        BLK_EIEOS: w = 32'hFF00_FF00;
        default:   ;
      endcase
      if (i == 0 && kind != BLK_DATA) begin
        w[7:0] = id;
        // Keep symbol 1 off FF so a 00 id stays an other set
        if (kind == BLK_OS_OTHER && w[15:8] == 8'hFF) begin
          w[15:8] = 8'h00;
        end
      end
      push_word(sync, w, kind, i);
    end
  endtask

  task automatic apply_reset(input logic [2:0] lane_sel);
    @(posedge clk);
    #1;
    rst  = 1'b1;
    lane = lane_sel;
    // Words still in the pipeline are lost on reset
    exp_scr_q.delete();
    exp_rx_q.delete();
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    model_lfsr = gen3_seed[lane_sel];
  endtask

  // Waits for the pipeline to empty, gives up 16 cycles after the last input
  task automatic wait_drained();
    int idle;
    idle = 0;
    while ((stim_q.size() != 0 || exp_scr_q.size() != 0 || exp_rx_q.size() != 0)
           && idle < 16) begin
      @(posedge clk);
      if (stim_q.size() == 0) begin
        idle++;
      end
    end
    if (exp_scr_q.size() != 0 || exp_rx_q.size() != 0) begin
      other_errors++;
      $display("Pipeline drained with %0d scrambled and %0d recovered words never output",
               exp_scr_q.size(), exp_rx_q.size());
      exp_scr_q.delete();
      exp_rx_q.delete();
    end
  endtask

  task automatic start_test();
    err_mark = errors + other_errors;
  endtask

  task automatic finish_test(input int num, input string name);
    int n;
    wait_drained();
    n = errors + other_errors - err_mark;
    if (n == 0) begin
      $display("Test %0d (%s): passed", num, name);
    end else begin
      $display("Test %0d (%s): %0d errors", num, name, n);
    end
  endtask

  // One word per cycle unless a random gap is drawn
  always @(posedge clk) begin : drive
    #1;
    if (stim_q.size() != 0 && !draw_gap()) begin
      stim_word = stim_q.pop_front();
      valid     = 1'b1;
      sync_hdr  = sync_hdr_t'(stim_word[33:32]);
      data      = stim_word[31:0];
    end else begin
      valid = 1'b0;
      // Junk on the bus during gaps
      data  = $random(seed);
    end
  end

  // Outputs settle after the rising edge, so check on the falling one
  always @(negedge clk) begin : compare
    if (!rst && scr_valid) begin
      if (exp_scr_q.size() == 0) begin
        errors++;
        $display("Scrambled word came out at %0d ns with none expected", $time);
      end else begin
        scr_exp = exp_scr_q.pop_front();
        compare_value("scr_data_o", scr_data, scr_exp[31:0]);
        compare_value("scr_sync_o", {30'd0, scr_sync}, {30'd0, scr_exp[33:32]});
      end
    end
    if (!rst && rx_valid) begin
      errors_before_rx = errors;
      if (exp_rx_q.size() == 0) begin
        errors++;
        $display("Recovered word came out at %0d ns with none expected", $time);
      end else begin
        rx_exp = exp_rx_q.pop_front();
        compare_value("rx_data_o", rx_data, rx_exp[31:0]);
        compare_value("rx_sync_o", {30'd0, rx_sync}, {30'd0, rx_exp[33:32]});
      end
      rx_errors += errors - errors_before_rx;
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : run
    rst        = 1'b1;
    lane       = 3'd0;
    valid      = 1'b0;
    sync_hdr   = SYNC_DATA;
    data       = '0;
    gap_pct    = 0;
    model_lfsr = '0;

    start_test();
    apply_reset(3'd0);
    repeat (3) send_block(BLK_DATA, 8'h00);
    wait_drained();
    // New lane needs a reset to pick up its seed
    apply_reset(3'd5);
    repeat (3) send_block(BLK_DATA, 8'h00);
    finish_test(1, "data blocks on lanes 0 and 5");

    start_test();
    send_block(BLK_TS, SYM_TS1);
    send_block(BLK_TS, SYM_TS2);
    send_block(BLK_DATA, 8'h00);
    finish_test(2, "TS1 and TS2 blocks");

    start_test();
    send_block(BLK_SKP, SYM_SKP);
    send_block(BLK_DATA, 8'h00);
    send_block(BLK_OS_OTHER, 8'h55);
    // 00 id without the FF fill
    send_block(BLK_OS_OTHER, 8'h00);
    send_block(BLK_DATA, 8'h00);
    finish_test(3, "SKP and other ordered sets");

    start_test();
    send_block(BLK_EIEOS, SYM_EIEOS);
    repeat (2) send_block(BLK_DATA, 8'h00);
    finish_test(4, "EIEOS reseed");

    start_test();
    gap_pct = 25;
    apply_reset(3'd3);
    repeat (2) send_block(BLK_DATA, 8'h00);
    send_block(BLK_TS, SYM_TS1);
    send_block(BLK_SKP, SYM_SKP);
    send_block(BLK_DATA, 8'h00);
    send_block(BLK_OS_OTHER, 8'h55);
    send_block(BLK_EIEOS, SYM_EIEOS);
    send_block(BLK_DATA, 8'h00);
    wait_drained();
    // Half a block, then reset in the middle of it
    for (int i = 0; i < 2; i++) begin
      part_word = $random(seed);
      push_word(2'b01, part_word, BLK_DATA, i);
    end
    // Reset while both words are still in flight
    while (stim_q.size() != 0) begin
      @(posedge clk);
    end
    apply_reset(3'd3);
    send_block(BLK_DATA, 8'h00);
    send_block(BLK_TS, SYM_TS2);
    finish_test(6, "gaps and mid-block reset");
    gap_pct = 0;

    if (rx_errors == 0) begin
      $display("Test 5 (loopback recovery over all tests): passed");
    end else begin
      $display("Test 5 (loopback recovery over all tests): %0d errors", rx_errors);
    end
    $display("Checks: %0d, errors: %0d", checks, errors + other_errors);
    if (errors + other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+src
src/pcie_sym_pkg.sv
src/gen3_lfsr_pkg.sv
src/gen3_block_tracker.sv
src/gen3_scrambler.sv
src/gen3_lane_loopback.sv
tb/gen3_lane_asserts.sv
tb/gen3_lane_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= gen3_lane_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard src/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
	  --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(OBJ_DIR)
